// ==== source/exec_config.svh ====
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// Integer data path width
`define XLEN 64

// Width of the W-suffix operations
`define WORDLEN 32

// Register file and CSR addressing
`define REG_ADDR_W 5
`define CSR_ADDR_W 12

// Shift amounts, full and word
`define SHAMT_W 6
`define SHAMTW_W 5

`endif

// ==== source/riscvPkg.sv ====
`include "exec_config.svh"

package riscvPkg;

  // Major opcodes handled by the execute stage
  typedef enum logic [6:0] {
    OP_IMM    = 7'b0010011,
    OP        = 7'b0110011,
    AUIPC     = 7'b0010111,
    LUI       = 7'b0110111,
    JAL       = 7'b1101111,
    JALR      = 7'b1100111,
    BRANCH    = 7'b1100011,
    OP_IMM_32 = 7'b0011011,
    OP_32     = 7'b0111011,
    SYSTEM    = 7'b1110011
  } opcode_e;

  typedef enum logic [2:0] {
    ADD_SUB = 3'b000,
    SLL     = 3'b001,
    SLT     = 3'b010,
    SLTU    = 3'b011,
    XOR     = 3'b100,
    SRL_SRA = 3'b101,
    OR      = 3'b110,
    AND     = 3'b111
  } aluFunct3_e;

  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branchFunct3_e;

  // Bit 2 set means the zimm form
  typedef enum logic [2:0] {
    CSRRW  = 3'b001,
    CSRRS  = 3'b010,
    CSRRC  = 3'b011,
    CSRRWI = 3'b101,
    CSRRSI = 3'b110,
    CSRRCI = 3'b111
  } csrFunct3_e;

  // Selects SUB and SRA variants
  localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

  // CSR address sits in the low bits of the I-type immediate
  typedef struct packed {
    logic [`XLEN-`CSR_ADDR_W-1:0] upper;
    logic [`CSR_ADDR_W-1:0]       csrAddr;
  } csrImm_t;

  typedef union packed {
    logic signed [`XLEN-1:0] value;
    csrImm_t                 csr;
  } immWord_u;

endpackage

// ==== source/execPkg.sv ====
`include "exec_config.svh"

package execPkg;

  // One decoded instruction as issued to execute
  typedef struct packed {
    logic [`XLEN-1:0]       instAddr;
    logic [`REG_ADDR_W-1:0] rdAddr;
    logic                   rdWriteEnable;
    logic [`XLEN-1:0]       rs1Data;
    logic [`XLEN-1:0]       rs2Data;
    riscvPkg::immWord_u     imm;
    riscvPkg::opcode_e      opCode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic [`SHAMT_W-1:0]    shamt;
    logic [`REG_ADDR_W-1:0] zimm;
    logic                   csrWriteEnable;
    logic [`XLEN-1:0]       csrReadData;
  } exIssue_t;

  typedef struct packed {
    logic [`REG_ADDR_W-1:0] rdAddr;
    logic                   rdWriteEnable;
    logic [`XLEN-1:0]       rdWriteData;
  } exResult_t;

  typedef struct packed {
    logic             jumpFlag;
    logic [`XLEN-1:0] jumpAddr;
  } redirect_t;

  typedef struct packed {
    logic                   csrWriteEnable;
    logic [`CSR_ADDR_W-1:0] csrWriteAddr;
    logic [`XLEN-1:0]       csrWriteData;
  } csrWrite_t;

endpackage

// ==== source/intAlu.sv ====
`timescale 1ns/100ps
`include "exec_config.svh"

module intAlu (
  input  execPkg::exIssue_t Issue,
  output logic [`XLEN-1:0]  AluResult
);
  import riscvPkg::*;

  logic                  isImm;
  logic                  isAlt;
  logic                  subSel;
  logic [`XLEN-1:0]      rs1;
  logic [`XLEN-1:0]      opB;
  logic [`SHAMT_W-1:0]   shAmt;
  logic [`SHAMTW_W-1:0]  shAmtW;
  logic [`XLEN-1:0]      sraRes;
  logic [`WORDLEN-1:0]   sraResW;
  logic [`XLEN-1:0]      immShift;
  logic [`XLEN-1:0]      fullRes;
  logic [`WORDLEN-1:0]   wordRes;

  assign rs1    = Issue.rs1Data;
  assign isImm  = (Issue.opCode == OP_IMM) || (Issue.opCode == OP_IMM_32);
  assign isAlt  = (Issue.funct7 == FUNCT7_ALT);
  // No SUBI exists, so immediate forms always add
  assign subSel = isAlt && !isImm;
  assign opB    = isImm ? Issue.imm.value : Issue.rs2Data;

  // Register shifts take the amount from rs2
  assign shAmt  = isImm ? Issue.shamt : Issue.rs2Data[`SHAMT_W-1:0];
  assign shAmtW = isImm ? Issue.shamt[`SHAMTW_W-1:0] : Issue.rs2Data[`SHAMTW_W-1:0];

  // Kept apart so the arithmetic shift stays signed
  assign sraRes  = $signed(rs1) >>> shAmt;
  assign sraResW = $signed(rs1[`WORDLEN-1:0]) >>> shAmtW;

  assign immShift = Issue.imm.value << 12;

  // 64-bit register and immediate class
  always_comb begin
    fullRes = '0;
    case (aluFunct3_e'(Issue.funct3))
      ADD_SUB: fullRes = subSel ? rs1 - opB : rs1 + opB;
      SLL:     fullRes = rs1 << shAmt;
      SLT:     fullRes = {{(`XLEN-1){1'b0}}, $signed(rs1) < $signed(opB)};
      SLTU:    fullRes = {{(`XLEN-1){1'b0}}, rs1 < opB};
      XOR:     fullRes = rs1 ^ opB;
      SRL_SRA: fullRes = isAlt ? sraRes : rs1 >> shAmt;
      OR:      fullRes = rs1 | opB;
      AND:     fullRes = rs1 & opB;
      default: fullRes = '0;
    endcase
  end

  // Word class works on the low half only
  always_comb begin
    wordRes = '0;
    case (aluFunct3_e'(Issue.funct3))
      ADD_SUB: begin
        if (subSel) begin
          wordRes = rs1[`WORDLEN-1:0] - opB[`WORDLEN-1:0];
        end else begin
          wordRes = rs1[`WORDLEN-1:0] + opB[`WORDLEN-1:0];
        end
      end
      SLL:     wordRes = rs1[`WORDLEN-1:0] << shAmtW;
      SRL_SRA: wordRes = isAlt ? sraResW : rs1[`WORDLEN-1:0] >> shAmtW;
      default: wordRes = '0;
    endcase
  end

  always_comb begin
    case (Issue.opCode)
      OP, OP_IMM: AluResult = fullRes;
      OP_32, OP_IMM_32: begin
        AluResult = {{(`XLEN-`WORDLEN){wordRes[`WORDLEN-1]}}, wordRes};
      end
      LUI: begin
        AluResult = {{(`XLEN-`WORDLEN){immShift[`WORDLEN-1]}}, immShift[`WORDLEN-1:0]};
      end
      AUIPC:     AluResult = Issue.instAddr + immShift;
      // Link address
      JAL, JALR: AluResult = Issue.instAddr + `XLEN'd4;
      default:   AluResult = '0;
    endcase
  end

endmodule

// ==== source/branchUnit.sv ====
`timescale 1ns/100ps
`include "exec_config.svh"

module branchUnit (
  input  execPkg::exIssue_t  Issue,
  output execPkg::redirect_t Redirect
);
  import riscvPkg::*;

  logic             taken;
  logic [`XLEN-1:0] rs1;
  logic [`XLEN-1:0] rs2;
  logic [`XLEN-1:0] pcTarget;
  logic [`XLEN-1:0] jalrSum;

  assign rs1      = Issue.rs1Data;
  assign rs2      = Issue.rs2Data;
  assign pcTarget = Issue.instAddr + Issue.imm.value;
  assign jalrSum  = rs1 + Issue.imm.value;

  // Compare per funct3
  always_comb begin
    case (branchFunct3_e'(Issue.funct3))
      BEQ:     taken = (rs1 == rs2);
      BNE:     taken = (rs1 != rs2);
      BLT:     taken = ($signed(rs1) < $signed(rs2));
      BGE:     taken = ($signed(rs1) >= $signed(rs2));
      BLTU:    taken = (rs1 < rs2);
      BGEU:    taken = (rs1 >= rs2);
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    Redirect = '0;
    case (Issue.opCode)
      JAL: begin
        Redirect.jumpFlag = 1'b1;
        Redirect.jumpAddr = pcTarget;
      end
      JALR: begin
        Redirect.jumpFlag = 1'b1;
        // Target LSB forced to zero
        Redirect.jumpAddr = {jalrSum[`XLEN-1:1], 1'b0};
      end
      BRANCH: begin
        Redirect.jumpFlag = taken;
        Redirect.jumpAddr = pcTarget;
      end
      default: Redirect = '0;
    endcase
  end

endmodule

// ==== source/csrWriteCalc.sv ====
`timescale 1ns/100ps
`include "exec_config.svh"

module csrWriteCalc (
  input  execPkg::exIssue_t  Issue,
  output execPkg::csrWrite_t CsrWrite
);
  import riscvPkg::*;

  logic             knownOp;
  logic [`XLEN-1:0] srcVal;
  logic [`XLEN-1:0] csrData;

  // I forms use zero-extended zimm instead of rs1
  assign srcVal = Issue.funct3[2] ? {{(`XLEN-`REG_ADDR_W){1'b0}}, Issue.zimm}
                                  : Issue.rs1Data;

  always_comb begin
    knownOp = 1'b1;
    case (csrFunct3_e'(Issue.funct3))
      CSRRW, CSRRWI: csrData = srcVal;
      CSRRS, CSRRSI: csrData = Issue.csrReadData | srcVal;
      CSRRC, CSRRCI: csrData = Issue.csrReadData & ~srcVal;
      default: begin
        knownOp = 1'b0;
        csrData = '0;
      end
    endcase
  end

  always_comb begin
    CsrWrite = '0;
    if ((Issue.opCode == SYSTEM) && knownOp) begin
      CsrWrite.csrWriteEnable = Issue.csrWriteEnable;
      CsrWrite.csrWriteAddr   = Issue.imm.csr.csrAddr;
      CsrWrite.csrWriteData   = csrData;
    end
  end

endmodule

// ==== source/execStage.sv ====
`timescale 1ns/100ps
`include "exec_config.svh"

module execStage (
  input  logic               Clk,
  input  logic               rst,
  input  logic               InValid,
  input  execPkg::exIssue_t  Issue,
  output logic               ResultValid,
  output execPkg::exResult_t Result,
  output execPkg::redirect_t Redirect,
  output execPkg::csrWrite_t CsrWrite
);
  import riscvPkg::*;
  import execPkg::*;

  logic [`XLEN-1:0] aluResult;
  logic [`XLEN-1:0] rdData;
  redirect_t        redirectNext;
  csrWrite_t        csrWriteNext;

  intAlu intAluInst (
    .Issue     (Issue),
    .AluResult (aluResult)
  );

  branchUnit branchUnitInst (
    .Issue    (Issue),
    .Redirect (redirectNext)
  );

  csrWriteCalc csrWriteCalcInst (
    .Issue    (Issue),
    .CsrWrite (csrWriteNext)
  );

  // CSR instructions return the old CSR value in rd
  assign rdData = (Issue.opCode == SYSTEM) ? Issue.csrReadData : aluResult;

  always_ff @(posedge Clk) begin
    if (rst) begin
      ResultValid             <= 1'b0;
      Result.rdWriteEnable    <= 1'b0;
      Redirect.jumpFlag       <= 1'b0;
      CsrWrite.csrWriteEnable <= 1'b0;
    end else begin
      // Idle cycles clear every control bit
      ResultValid             <= InValid;
      Result.rdWriteEnable    <= InValid & Issue.rdWriteEnable;
      Redirect.jumpFlag       <= InValid & redirectNext.jumpFlag;
      CsrWrite.csrWriteEnable <= InValid & csrWriteNext.csrWriteEnable;
      if (InValid) begin
        Result.rdAddr          <= Issue.rdAddr;
        Result.rdWriteData     <= rdData;
        Redirect.jumpAddr      <= redirectNext.jumpAddr;
        CsrWrite.csrWriteAddr  <= csrWriteNext.csrWriteAddr;
        CsrWrite.csrWriteData  <= csrWriteNext.csrWriteData;
      end
    end
  end

endmodule

// ==== tests/execStageChecker.sv ====
`timescale 1ns/100ps

module execStageChecker (
  input logic               Clk,
  input logic               rst,
  input logic               InValid,
  input execPkg::exIssue_t  Issue,
  input logic               ResultValid,
  input execPkg::exResult_t Result,
  input execPkg::redirect_t Redirect,
  input execPkg::csrWrite_t CsrWrite
);
  import riscvPkg::*;

  resetClearsValid: assert property (@(posedge Clk) rst |=> !ResultValid)
    else $error("ResultValid is high in the cycle after reset");

  // Control bits only travel with a valid result
  controlNeedsValid: assert property (@(posedge Clk) disable iff (rst)
    !ResultValid |-> !(Result.rdWriteEnable || Redirect.jumpFlag || CsrWrite.csrWriteEnable))
    else $error("A control bit is high while ResultValid is low");

  jalrTargetAligned: assert property (@(posedge Clk) disable iff (rst)
    (InValid && Issue.opCode == JALR) |=> !Redirect.jumpAddr[0])
    else $error("JALR target address has bit 0 set");

endmodule

bind execStage execStageChecker checkerInst (
  .Clk(Clk), .rst(rst), .InValid(InValid), .Issue(Issue), .ResultValid(ResultValid),
  .Result(Result), .Redirect(Redirect), .CsrWrite(CsrWrite)
);

// ==== tests/execStageTb.sv ====
`timescale 1ns/100ps
`include "exec_config.svh"

module execStageTb;
  import riscvPkg::*;
  import execPkg::*;

  typedef struct packed {
    exIssue_t  issue;
    logic      inValid;
    exResult_t res;
    redirect_t red;
    csrWrite_t csr;
  } tbRow_t;

  localparam logic [`XLEN-1:0] SIGN_BIT = {1'b1, {(`XLEN-1){1'b0}}};

  logic      Clk;
  logic      rst;
  logic      InValid;
  exIssue_t  Issue;
  logic      ResultValid;
  exResult_t Result;
  redirect_t Redirect;
  csrWrite_t CsrWrite;
  tbRow_t    rows[$];
  int        cycles = 0;
  int        cycleLimit = 0;

  execStage dut_i (
    .Clk(Clk), .rst(rst), .InValid(InValid), .Issue(Issue), .ResultValid(ResultValid),
    .Result(Result), .Redirect(Redirect), .CsrWrite(CsrWrite)
  );

  initial begin
    Clk = 1'b0;
    forever #4 Clk = ~Clk;
  end

  always @(posedge Clk) begin
    cycles++;
    if (cycleLimit > 0 && cycles >= cycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("ERRORS FOUND");
      $fatal(1, "Simulation stopped by the cycle limit");
    end
  end

  function automatic logic [`XLEN-1:0] sext32(input logic [`WORDLEN-1:0] w);
    return {{(`XLEN-`WORDLEN){w[`WORDLEN-1]}}, w};
  endfunction

  // Reference results from the RV64I definitions
  function automatic logic [`XLEN-1:0] refAlu(input exIssue_t ins);
    logic             useImm;
    logic             alt;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [5:0]       sh;
    useImm = (ins.opCode == OP_IMM) || (ins.opCode == OP_IMM_32);
    alt    = (ins.funct7 == FUNCT7_ALT);
    a      = ins.rs1Data;
    b      = useImm ? ins.imm.value : ins.rs2Data;
    sh     = useImm ? ins.shamt : ins.rs2Data[5:0];
    case (ins.opCode)
      OP, OP_IMM: begin
        case (ins.funct3)
          3'b000: return (alt && ins.opCode == OP) ? a - b : a + b;
          3'b001: return a << sh;
          // Signed compare via flipped sign bits
          3'b010: return ((a ^ SIGN_BIT) < (b ^ SIGN_BIT)) ? 64'd1 : 64'd0;
          3'b011: return (a < b) ? 64'd1 : 64'd0;
          3'b100: return a ^ b;
          3'b101: begin
            if (alt) begin
              return $signed(a) >>> sh;
            end
            return a >> sh;
          end
          3'b110: return a | b;
          default: return a & b;
        endcase
      end
      OP_32, OP_IMM_32: begin
        case (ins.funct3)
          3'b000: return sext32((alt && ins.opCode == OP_32) ? a[31:0] - b[31:0]
                                                              : a[31:0] + b[31:0]);
          3'b001: return sext32(a[31:0] << sh[4:0]);
          3'b101: begin
            if (alt) begin
              return sext32($signed(a[31:0]) >>> sh[4:0]);
            end
            return sext32(a[31:0] >> sh[4:0]);
          end
          default: return '0;
        endcase
      end
      LUI:       return sext32({ins.imm.value[19:0], 12'h000});
      AUIPC:     return ins.instAddr + {ins.imm.value[51:0], 12'h000};
      JAL, JALR: return ins.instAddr + 64'd4;
      default:   return '0;
    endcase
  endfunction

  function automatic redirect_t refRedirect(input exIssue_t ins);
    redirect_t        r;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    a = ins.rs1Data;
    b = ins.rs2Data;
    r = '0;
    case (ins.opCode)
      JAL:  r = '{1'b1, ins.instAddr + ins.imm.value};
      JALR: r = '{1'b1, (a + ins.imm.value) & ~64'd1};
      BRANCH: begin
        r.jumpAddr = ins.instAddr + ins.imm.value;
        case (ins.funct3)
          3'b000: r.jumpFlag = (a == b);
          3'b001: r.jumpFlag = (a != b);
          3'b100: r.jumpFlag = ((a ^ SIGN_BIT) < (b ^ SIGN_BIT));
          3'b101: r.jumpFlag = ((a ^ SIGN_BIT) >= (b ^ SIGN_BIT));
          3'b110: r.jumpFlag = (a < b);
          3'b111: r.jumpFlag = (a >= b);
          default: r.jumpFlag = 1'b0;
        endcase
      end
      default: r = '0;
    endcase
    return r;
  endfunction

  function automatic exIssue_t mkIssue(input opcode_e op, input logic [2:0] f3,
                                       input logic [6:0] f7, input logic [`XLEN-1:0] a,
                                       input logic [`XLEN-1:0] b, input logic [`XLEN-1:0] imm);
    exIssue_t ins;
    ins               = '0;
    ins.instAddr      = 64'h0000_0000_8000_1000;
    ins.rdAddr        = 5'($urandom());
    ins.rdWriteEnable = 1'b1;
    ins.rs1Data       = a;
    ins.rs2Data       = b;
    ins.imm.value     = imm;
    ins.opCode        = op;
    ins.funct3        = f3;
    ins.funct7        = f7;
    ins.shamt         = imm[5:0];
    return ins;
  endfunction

  task automatic addRow(input exIssue_t ins, input logic v, input logic [`XLEN-1:0] rd,
                        input redirect_t red, input csrWrite_t csr);
    tbRow_t row;
    row.issue  = ins;
    row.inValid = v;
    row.res    = '{ins.rdAddr, ins.rdWriteEnable & v, rd};
    row.red    = red;
    row.red.jumpFlag = red.jumpFlag & v;
    row.csr    = csr;
    row.csr.csrWriteEnable = csr.csrWriteEnable & v;
    rows.push_back(row);
  endtask

  task automatic buildTable();
    csrFunct3_e       csrF3[6] = '{CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI};
    logic [`XLEN-1:0] csrExp[6] = '{64'h0F0F, 64'h0FFF, 64'h00F0, 64'h0013, 64'h00FF, 64'h00EC};
    opcode_e          aluOps[4] = '{OP, OP_IMM, OP_32, OP_IMM_32};
    logic [2:0]       wordF3[3] = '{3'd0, 3'd1, 3'd5};
    logic [2:0]       brF3[6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    exIssue_t         ins;
    opcode_e          op;
    logic [2:0]       f3;
    logic [6:0]       f7;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] imm;
    logic [11:0]      r12;
    logic             v;
    // Word results that need sign extension
    addRow(mkIssue(OP_32, 3'd0, 7'h00, 64'h7FFF_FFFF, 64'h1, 64'h0), 1'b1,
           64'hFFFF_FFFF_8000_0000, '0, '0);
    addRow(mkIssue(OP_32, 3'd0, FUNCT7_ALT, 64'h0, 64'h1, 64'h0), 1'b1, '1, '0, '0);
    addRow(mkIssue(OP_IMM_32, 3'd5, FUNCT7_ALT, 64'h8000_0000, 64'h0, 64'h4), 1'b1,
           64'hFFFF_FFFF_F800_0000, '0, '0);
    addRow(mkIssue(LUI, 3'd0, 7'h00, 64'h0, 64'h0, 64'h8_0000), 1'b1,
           64'hFFFF_FFFF_8000_0000, '0, '0);
    addRow(mkIssue(AUIPC, 3'd0, 7'h00, 64'h0, 64'h0, 64'h1), 1'b1, 64'h8000_2000, '0, '0);
    addRow(mkIssue(JAL, 3'd0, 7'h00, 64'h0, 64'h0, 64'h100), 1'b1, 64'h8000_1004,
           '{1'b1, 64'h8000_1100}, '0);
    // Idle gap between jumps
    addRow(mkIssue(JAL, 3'd0, 7'h00, 64'h0, 64'h0, 64'h100), 1'b0, 64'h0, '0, '0);
    addRow(mkIssue(JALR, 3'd0, 7'h00, 64'h2001, 64'h0, 64'h4), 1'b1, 64'h8000_1004,
           '{1'b1, 64'h2004}, '0);
    addRow(mkIssue(BRANCH, 3'd0, 7'h00, 64'h5, 64'h5, '1 << 3), 1'b1, 64'h0,
           '{1'b1, 64'h8000_0FF8}, '0);
    addRow(mkIssue(BRANCH, 3'd4, 7'h00, '1, 64'h1, '1 << 3), 1'b1, 64'h0,
           '{1'b1, 64'h8000_0FF8}, '0);
    addRow(mkIssue(BRANCH, 3'd6, 7'h00, '1, 64'h1, '1 << 3), 1'b1, 64'h0,
           '{1'b0, 64'h8000_0FF8}, '0);
    for (int k = 0; k < 6; k++) begin
      ins = mkIssue(SYSTEM, csrF3[k], 7'h00, 64'h0F0F, 64'h0, 64'h300);
      ins.zimm           = 5'h13;
      ins.csrReadData    = 64'h00FF;
      ins.csrWriteEnable = 1'b1;
      addRow(ins, 1'b1, 64'h00FF, '0, '{1'b1, 12'h300, csrExp[k]});
    end
    // Random ALU and branch rows with occasional idle cycles
    for (int k = 0; k < 64; k++) begin
      a   = {$urandom(), $urandom()};
      b   = ($urandom_range(3, 0) == 0) ? a : {$urandom(), $urandom()};
      r12 = 12'($urandom());
      imm = {{52{r12[11]}}, r12};
      f7  = ($urandom_range(1, 0) == 1) ? FUNCT7_ALT : 7'h00;
      v   = ($urandom_range(7, 0) != 0);
      if (k % 4 == 3) begin
        op = BRANCH;
        f3 = brF3[$urandom_range(5, 0)];
      end else begin
        op = aluOps[$urandom_range(3, 0)];
        f3 = (op == OP_32 || op == OP_IMM_32) ? wordF3[$urandom_range(2, 0)]
                                              : 3'($urandom_range(7, 0));
      end
      ins = mkIssue(op, f3, f7, a, b, imm);
      addRow(ins, v, refAlu(ins), refRedirect(ins), '0);
    end
  endtask

  task automatic reportMismatch(input string msg);
    $display("ERR at %0t: %s", $time, msg);
    $display("ERRORS FOUND");
    $fatal(1, "Stopped at the first mismatch");
  endtask

  task automatic checkValid(input logic got, input logic exp);
    if (got !== exp) begin
      reportMismatch($sformatf("ResultValid got %b expected %b", got, exp));
    end
  endtask

  // Data fields are only compared for issued rows
  task automatic checkResult(input exResult_t got, input exResult_t exp, input logic full);
    if (full ? (got !== exp) : (got.rdWriteEnable !== exp.rdWriteEnable)) begin
      reportMismatch($sformatf("Result got %h expected %h", got, exp));
    end
  endtask

  task automatic checkRedirect(input redirect_t got, input redirect_t exp, input logic full);
    if (full ? (got !== exp) : (got.jumpFlag !== exp.jumpFlag)) begin
      reportMismatch($sformatf("Redirect got %h expected %h", got, exp));
    end
  endtask

  task automatic checkCsrWrite(input csrWrite_t got, input csrWrite_t exp, input logic full);
    if (full ? (got !== exp) : (got.csrWriteEnable !== exp.csrWriteEnable)) begin
      reportMismatch($sformatf("CsrWrite got %h expected %h", got, exp));
    end
  endtask

  initial begin
    int seedValue;
    seedValue = $urandom(14210);
    rst     = 1'b1;
    // A jump held valid during reset must not reach the outputs
    InValid = 1'b1;
    Issue   = mkIssue(JAL, 3'd0, 7'h00, 64'h0, 64'h0, 64'h100);
    buildTable();
    cycleLimit = rows.size() + 10 + 20;
    repeat (10) @(posedge Clk);
    @(negedge Clk);
    // Quiet outputs before the first issue
    checkValid(ResultValid, 1'b0);
    checkResult(Result, '0, 1'b0);
    checkRedirect(Redirect, '0, 1'b0);
    checkCsrWrite(CsrWrite, '0, 1'b0);
    rst     = 1'b0;
    InValid = 1'b0;
    Issue   = '0;
    @(negedge Clk);
    foreach (rows[i]) begin
      Issue   = rows[i].issue;
      InValid = rows[i].inValid;
      @(negedge Clk);
      checkValid(ResultValid, rows[i].inValid);
      checkResult(Result, rows[i].res, rows[i].inValid);
      checkRedirect(Redirect, rows[i].red, rows[i].inValid);
      checkCsrWrite(CsrWrite, rows[i].csr, rows[i].inValid);
    end
    $display("NO ERRORS");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+source
source/riscvPkg.sv
source/execPkg.sv
source/intAlu.sv
source/branchUnit.sv
source/csrWriteCalc.sv
source/execStage.sv
tests/execStageChecker.sv
tests/execStageTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := execStageTb
FILELIST  := vlog.f
OBJDIR    := obj_dir
VFLAGS    := --timing --assert
LINTFLAGS := --lint-only
SIMFLAGS  := --binary -Mdir $(OBJDIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIMFLAGS) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
